// File: Makefile
# Verilator build and run for the stream converter testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= axis_converter_tb
FILELIST  ?= axis_converter_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?=

SOURCES := $(wildcard common/*.sv common/*.svh design/*.sv axis_converter/*.sv verif/*.sv)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) $(SIM_ARGS)

clean:
	rm -rf $(OBJ_DIR)

// File: axis_converter/axis_downsizer.sv
////////////////////////////////////////////////////////////
// Splits buffered 256-bit beats into 64-bit lanes and puts
// the packet metadata on the first narrow beat.
////////////////////////////////////////////////////////////
`default_nettype none

`include "axis_defs.svh"

module axis_downsizer import axis_pkg::*; (
   input  wire logic              axi_aclk,
   input  wire logic              axi_resetn,
   // Input FIFO head
   input  wire axis_wide_beat_t   in_beat,
   input  wire logic              in_empty,
   output logic                   in_rd,
   // Metadata FIFO head
   input  wire pkt_meta_t         meta_in,
   input  wire logic              meta_empty,
   output logic                   meta_rd,
   // Output stream
   output axis_narrow_beat_t      m_beat,
   output pkt_meta_t              m_meta,
   output logic                   m_valid,
   input  wire logic              m_ready
);

   localparam int NARROW_W = `AXIS_M_DATA_WIDTH;
   localparam int NARROW_B = `AXIS_M_DATA_WIDTH / 8;

   dsz_state_t             state;
   dsz_state_t             state_next;
   logic [1:0]             lane;
   logic [1:0]             lane_nxt;
   logic [NARROW_B-1:0]    next_strb;
   logic                   narrow_last;
   logic                   xfer;

   ////////////////////////////////////////////////////////////
   // Lane select
   ////////////////////////////////////////////////////////////
   assign lane_nxt    = lane + 2'd1; // Wraps at 3, masked below
   assign next_strb   = (lane == 2'd3) ? '0 : in_beat.strb[lane_nxt*NARROW_B +: NARROW_B];
   assign narrow_last = in_beat.last & ((lane == 2'd3) | ~|next_strb);

   assign m_beat.data = in_beat.data[lane*NARROW_W +: NARROW_W];
   assign m_beat.strb = in_beat.strb[lane*NARROW_B +: NARROW_B];
   assign m_beat.last = narrow_last;
   // Metadata head on the first beat, zero on the rest of the packet
   assign m_meta      = (state == DSZ_WAIT_META) ? meta_in : '0;

   // Whole packet is buffered once its metadata exists
   always_comb begin
      case (state)
         DSZ_WAIT_META: m_valid = ~in_empty & ~meta_empty;
         DSZ_STREAM:    m_valid = ~in_empty;
         default:       m_valid = 1'b0;
      endcase
   end

   assign xfer    = m_valid & m_ready;
   assign in_rd   = xfer & ((lane == 2'd3) | narrow_last);
   assign meta_rd = xfer & (state == DSZ_WAIT_META);

   ////////////////////////////////////////////////////////////
   // FSM
   ////////////////////////////////////////////////////////////
   always_comb begin
      state_next = state;
      if (xfer) begin
         if (narrow_last) begin
            state_next = DSZ_WAIT_META;
         end else begin
            state_next = DSZ_STREAM;
         end
      end
   end

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         state <= DSZ_WAIT_META;
         lane  <= '0;
      end else begin
         state <= state_next;
         if (in_rd) begin
            lane <= '0;        // Next wide beat
         end else if (xfer) begin
            lane <= lane_nxt;
         end
      end
   end

   // Output held under back-pressure
   hold_a : assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
      (m_valid && !m_ready) |=> (m_valid && $stable(m_beat) && $stable(m_meta)));

endmodule

`default_nettype wire

// File: axis_converter/axis_len_counter.sv
////////////////////////////////////////////////////////////
// Byte counter for accepted input packets. Emits the tuser
// metadata word in the same cycle as the tlast beat.
////////////////////////////////////////////////////////////
`default_nettype none

`include "axis_defs.svh"

module axis_len_counter import axis_pkg::*; (
   input  wire logic            axi_aclk,
   input  wire logic            axi_resetn,
   input  wire logic            accept,
   input  wire axis_wide_beat_t beat,
   output logic                 meta_wr,
   output pkt_meta_t            meta
);

   localparam int STRB_W = `AXIS_S_DATA_WIDTH / 8;
   localparam int BYTES_W = $clog2(STRB_W) + 1;

   logic [BYTES_W-1:0]         beat_bytes; // Highest strobe index plus one
   logic [`AXIS_LEN_WIDTH-1:0] byte_count;
   logic [`AXIS_LEN_WIDTH-1:0] len_sum;

   always_comb begin
      beat_bytes = '0;
      for (int i = 0; i < STRB_W; i++) begin
         if (beat.strb[i]) beat_bytes = BYTES_W'(i + 1);
      end
   end

   assign len_sum = byte_count + `AXIS_LEN_WIDTH'(beat_bytes);

   // Running count, cleared after each packet
   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         byte_count <= '0;
      end else if (accept) begin
         byte_count <= beat.last ? '0 : len_sum;
      end
   end

   assign meta_wr       = accept & beat.last;
   assign meta.rsvd     = '0;
   assign meta.dst_port = `AXIS_PORT_WIDTH'(`AXIS_DEFAULT_DST_PORT);
   assign meta.src_port = `AXIS_PORT_WIDTH'(`AXIS_DEFAULT_SRC_PORT);
   assign meta.len      = len_sum;

   // Full beats inside a packet, contiguous low bytes at the end
   strb_shape_a : assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
      accept |-> (beat.last ? (beat.strb[0] && ((beat.strb & (beat.strb + 1'b1)) == '0))
                            : (&beat.strb)));

   pkt_len_a : assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
      meta_wr |-> (meta.len <= `AXIS_LEN_WIDTH'(`AXIS_MAX_PKT_BYTES)));

endmodule

`default_nettype wire

// File: axis_converter_top.f
+incdir+common
common/axis_pkg.sv
design/fallthrough_small_fifo.sv
axis_converter/axis_len_counter.sv
axis_converter/axis_downsizer.sv
design/axis_converter_top.sv
verif/axis_converter_tb.sv

// File: common/axis_defs.svh
////////////////////////////////////////////////////////////
// Width, depth and default-port macros for the 256 to 64
// stream converter. Include it wherever a macro is needed.
////////////////////////////////////////////////////////////
`ifndef AXIS_DEFS_SVH
`define AXIS_DEFS_SVH

// Stream widths
`define AXIS_S_DATA_WIDTH 256
`define AXIS_M_DATA_WIDTH 64
`define AXIS_USER_WIDTH 128

// Metadata fields
`define AXIS_LEN_WIDTH 16
`define AXIS_PORT_WIDTH 8

`define AXIS_MAX_PKT_BYTES 1600 // Largest packet in bytes

// One max packet is 50 wide beats, so 64 leaves headroom
`define AXIS_IN_FIFO_DEPTH_BITS 6
`define AXIS_META_FIFO_DEPTH_BITS 5

`define AXIS_DEFAULT_SRC_PORT 0
`define AXIS_DEFAULT_DST_PORT 1

`endif

// File: common/axis_pkg.sv
////////////////////////////////////////////////////////////
// Beat, metadata and state types shared by the converter.
////////////////////////////////////////////////////////////
`default_nettype none

`include "axis_defs.svh"

package axis_pkg;

   // One 256-bit input beat, 289 bits
   typedef struct packed {
      logic [`AXIS_S_DATA_WIDTH-1:0]   data;
      logic [`AXIS_S_DATA_WIDTH/8-1:0] strb;
      logic                            last;
   } axis_wide_beat_t;

   // One 64-bit output beat, 73 bits
   typedef struct packed {
      logic [`AXIS_M_DATA_WIDTH-1:0]   data;
      logic [`AXIS_M_DATA_WIDTH/8-1:0] strb;
      logic                            last;
   } axis_narrow_beat_t;

   // tuser word, length in the low bits
   typedef struct packed {
      logic [`AXIS_USER_WIDTH-`AXIS_LEN_WIDTH-2*`AXIS_PORT_WIDTH-1:0] rsvd;
      logic [`AXIS_PORT_WIDTH-1:0] dst_port;
      logic [`AXIS_PORT_WIDTH-1:0] src_port;
      logic [`AXIS_LEN_WIDTH-1:0]  len;
   } pkt_meta_t;

   typedef enum logic {
      DSZ_WAIT_META, // Packet not yet complete in the buffer
      DSZ_STREAM     // Sending lanes of the current packet
   } dsz_state_t;

endpackage

`default_nettype wire

// File: design/axis_converter_top.sv
////////////////////////////////////////////////////////////
// 256 to 64 bit AXI4-Stream converter with length metadata
// on tuser. Packets are buffered whole before they leave.
////////////////////////////////////////////////////////////
`default_nettype none

`include "axis_defs.svh"

module axis_converter_top import axis_pkg::*; (
   input  wire logic                            axi_aclk,
   input  wire logic                            axi_resetn,
   // Slave side
   input  wire logic [`AXIS_S_DATA_WIDTH-1:0]   s_axis_tdata,
   input  wire logic [`AXIS_S_DATA_WIDTH/8-1:0] s_axis_tstrb,
   input  wire logic                            s_axis_tlast,
   input  wire logic                            s_axis_tvalid,
   output logic                                 s_axis_tready,
   // Master side
   output logic      [`AXIS_M_DATA_WIDTH-1:0]   m_axis_tdata,
   output logic      [`AXIS_M_DATA_WIDTH/8-1:0] m_axis_tstrb,
   output logic                                 m_axis_tlast,
   output logic      [`AXIS_USER_WIDTH-1:0]     m_axis_tuser,
   output logic                                 m_axis_tvalid,
   input  wire logic                            m_axis_tready
);

   axis_wide_beat_t   s_beat;
   axis_wide_beat_t   in_head;
   axis_narrow_beat_t m_beat;
   pkt_meta_t         meta_wr_word;
   pkt_meta_t         meta_head;
   pkt_meta_t         m_meta;
   logic in_nearly_full, in_empty, in_rd;
   logic meta_nearly_full, meta_empty, meta_rd, meta_wr;
   logic accept;

   assign s_beat        = '{data: s_axis_tdata, strb: s_axis_tstrb, last: s_axis_tlast};
   assign s_axis_tready = ~in_nearly_full & ~meta_nearly_full;
   assign accept        = s_axis_tvalid & s_axis_tready;

   fallthrough_small_fifo #(
      .WIDTH          ($bits(axis_wide_beat_t)),
      .MAX_DEPTH_BITS (`AXIS_IN_FIFO_DEPTH_BITS)
   ) in_fifo (
      .clk (axi_aclk), .reset (~axi_resetn),
      .din (s_beat), .wr_en (accept), .rd_en (in_rd),
      .dout (in_head), .nearly_full (in_nearly_full), .empty (in_empty)
   );

   axis_len_counter len_counter (
      .axi_aclk, .axi_resetn,
      .accept, .beat (s_beat), .meta_wr, .meta (meta_wr_word)
   );

   fallthrough_small_fifo #(
      .WIDTH          ($bits(pkt_meta_t)),
      .MAX_DEPTH_BITS (`AXIS_META_FIFO_DEPTH_BITS)
   ) meta_fifo (
      .clk (axi_aclk), .reset (~axi_resetn),
      .din (meta_wr_word), .wr_en (meta_wr), .rd_en (meta_rd),
      .dout (meta_head), .nearly_full (meta_nearly_full), .empty (meta_empty)
   );

   axis_downsizer downsizer (
      .axi_aclk, .axi_resetn,
      .in_beat (in_head), .in_empty, .in_rd,
      .meta_in (meta_head), .meta_empty, .meta_rd,
      .m_beat, .m_meta, .m_valid (m_axis_tvalid), .m_ready (m_axis_tready)
   );

   // Output unpacking
   assign m_axis_tdata = m_beat.data;
   assign m_axis_tstrb = m_beat.strb;
   assign m_axis_tlast = m_beat.last;
   assign m_axis_tuser = m_meta;

endmodule

`default_nettype wire

// File: design/fallthrough_small_fifo.sv
////////////////////////////////////////////////////////////
// Register-array FIFO with the head word always on dout.
// Flags come from an occupancy count.
////////////////////////////////////////////////////////////
`default_nettype none

module fallthrough_small_fifo #(
   parameter int WIDTH          = 72,
   parameter int MAX_DEPTH_BITS = 3
) (
   input  wire logic             clk,
   input  wire logic             reset, // Active high, synchronous
   input  wire logic [WIDTH-1:0] din,
   input  wire logic             wr_en,
   input  wire logic             rd_en,
   output logic      [WIDTH-1:0] dout,
   output logic                  nearly_full,
   output logic                  empty
);

   localparam int DEPTH = 2 ** MAX_DEPTH_BITS;
   localparam logic [MAX_DEPTH_BITS:0] FULL_LEVEL = (MAX_DEPTH_BITS+1)'(DEPTH);
   localparam logic [MAX_DEPTH_BITS:0] NF_LEVEL   = (MAX_DEPTH_BITS+1)'(DEPTH - 2);

   logic [WIDTH-1:0]          mem [DEPTH];
   logic [MAX_DEPTH_BITS-1:0] wr_ptr;
   logic [MAX_DEPTH_BITS-1:0] rd_ptr;
   logic [MAX_DEPTH_BITS:0]   count;

   // Storage
   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= din;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en) wr_ptr <= wr_ptr + 1'b1;
         if (rd_en) rd_ptr <= rd_ptr + 1'b1;
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count; // Both or neither
         endcase
      end
   end

   assign dout        = mem[rd_ptr];
   assign empty       = (count == '0);
   assign nearly_full = (count >= NF_LEVEL); // Two or fewer free

   wr_not_full_a : assert property (@(posedge clk) disable iff (reset)
      wr_en |-> (count != FULL_LEVEL || rd_en));

   rd_not_empty_a : assert property (@(posedge clk) disable iff (reset)
      rd_en |-> (count != '0));

endmodule

`default_nettype wire

// File: verif/axis_converter_tb.sv
////////////////////////////////////////////////////////////
// Self-checking testbench for the 256 to 64 converter.
// Packets go in, a reference queue checks every output beat.
////////////////////////////////////////////////////////////
`default_nettype none

`include "axis_defs.svh"

module axis_converter_tb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int S_BYTES       = `AXIS_S_DATA_WIDTH / 8;
   localparam int M_BYTES       = `AXIS_M_DATA_WIDTH / 8;
   localparam int IN_DEPTH      = 2 ** `AXIS_IN_FIFO_DEPTH_BITS;
   localparam int WAIT_LIMIT    = 2000; // Cycles allowed per wait
   localparam int STALL_MIN_LEN = 1000; // At least 32 wide beats

   typedef byte unsigned byte_q_t[$];

   typedef struct packed {
      logic [`AXIS_M_DATA_WIDTH-1:0] data;
      logic [M_BYTES-1:0]            strb;
      logic                          last;
      logic                          first;
      logic [`AXIS_USER_WIDTH-1:0]   user;
   } exp_beat_t;

   logic                            axi_aclk = 1'b0;
   logic                            axi_resetn;
   logic [`AXIS_S_DATA_WIDTH-1:0]   s_axis_tdata;
   logic [S_BYTES-1:0]              s_axis_tstrb;
   logic                            s_axis_tlast;
   logic                            s_axis_tvalid;
   logic                            s_axis_tready;
   logic [`AXIS_M_DATA_WIDTH-1:0]   m_axis_tdata;
   logic [M_BYTES-1:0]              m_axis_tstrb;
   logic                            m_axis_tlast;
   logic [`AXIS_USER_WIDTH-1:0]     m_axis_tuser;
   logic                            m_axis_tvalid;
   logic                            m_axis_tready;

   exp_beat_t exp_q[$];
   integer    seed = 32'h8f933f71;
   integer    bp_seed;
   int        ready_mode = 0; // 0 ready, 1 random, 2 stalled
   int        in_lasts = 0;
   int        out_lasts = 0;
   int        accepted_beats = 0;
   int        short_lens[5] = '{1, 8, 9, 32, 33};
   string     test_name = "reset";

   always #2 axi_aclk = ~axi_aclk;

   axis_converter_top axis_converter_top_inst (
      .axi_aclk, .axi_resetn,
      .s_axis_tdata, .s_axis_tstrb, .s_axis_tlast, .s_axis_tvalid, .s_axis_tready,
      .m_axis_tdata, .m_axis_tstrb, .m_axis_tlast, .m_axis_tuser, .m_axis_tvalid,
      .m_axis_tready
   );

   task automatic check_value(input string name, input logic [127:0] expected,
                              input logic [127:0] actual);
      if (expected !== actual) begin
         $display("CHECK FAILED: %s expected %0h actual %0h", name, expected, actual);
         $display("Done: errors found");
         $fatal(1, "Stopping at first mismatch");
      end
   endtask

   task automatic report_timeout(input string what);
      $display("Timeout in test %s while waiting for %s", test_name, what);
      $display("Done: errors found");
      $fatal(1, "Simulation stopped by timeout");
   endtask

   // Reference model: 8 bytes per narrow beat, metadata on the first
   function automatic void build_expected(input byte_q_t bytes);
      exp_beat_t b;
      int        len;
      int        nbeats;
      len    = bytes.size();
      nbeats = (len + M_BYTES - 1) / M_BYTES;
      for (int k = 0; k < nbeats; k++) begin
         b = '0;
         for (int j = 0; j < M_BYTES; j++) begin
            if (k * M_BYTES + j < len) begin
               b.data[j*8 +: 8] = bytes[k*M_BYTES + j];
               b.strb[j]        = 1'b1;
            end
         end
         b.last  = (k == nbeats - 1);
         b.first = (k == 0);
         b.user[`AXIS_LEN_WIDTH-1:0] = `AXIS_LEN_WIDTH'(len);
         b.user[`AXIS_LEN_WIDTH +: `AXIS_PORT_WIDTH] = `AXIS_PORT_WIDTH'(`AXIS_DEFAULT_SRC_PORT);
         b.user[`AXIS_LEN_WIDTH+`AXIS_PORT_WIDTH +: `AXIS_PORT_WIDTH] =
            `AXIS_PORT_WIDTH'(`AXIS_DEFAULT_DST_PORT);
         exp_q.push_back(b);
      end
   endfunction

   ////////////////////////////////////////////////////////////
   // Stimulus tasks, called and returning on a falling edge
   ////////////////////////////////////////////////////////////
   task automatic drive_beat(input logic [`AXIS_S_DATA_WIDTH-1:0] data,
                             input logic [S_BYTES-1:0] strb, input logic last);
      int waited;
      s_axis_tdata  = data;
      s_axis_tstrb  = strb;
      s_axis_tlast  = last;
      s_axis_tvalid = 1'b1;
      waited = 0;
      do begin
         @(posedge axi_aclk);
         waited++;
         if (waited > WAIT_LIMIT) report_timeout("s_axis_tready");
      end while (!s_axis_tready);
      @(negedge axi_aclk);
   endtask

   task automatic send_packet(input byte_q_t bytes);
      logic [`AXIS_S_DATA_WIDTH-1:0] data;
      logic [S_BYTES-1:0]            strb;
      int                            len;
      int                            nwide;
      len   = bytes.size();
      nwide = (len + S_BYTES - 1) / S_BYTES;
      build_expected(bytes);
      for (int w = 0; w < nwide; w++) begin
         data = '0;
         strb = '0;
         for (int j = 0; j < S_BYTES; j++) begin
            if (w * S_BYTES + j < len) begin
               data[j*8 +: 8] = bytes[w*S_BYTES + j];
               strb[j]        = 1'b1;
            end
         end
         drive_beat(data, strb, w == nwide - 1);
      end
   endtask

   task automatic send_random_packet(input int min_len, input int max_len);
      byte_q_t bytes;
      int      len;
      len = min_len + int'({$random(seed)} % (max_len - min_len + 1));
      for (int i = 0; i < len; i++) bytes.push_back(8'($random(seed)));
      send_packet(bytes);
   endtask

   task automatic idle_input();
      s_axis_tvalid = 1'b0;
      s_axis_tlast  = 1'b0;
   endtask

   task automatic set_ready_mode(input int mode);
      @(posedge axi_aclk);
      ready_mode = mode;
      @(negedge axi_aclk);
   endtask

   task automatic wait_drain();
      int waited;
      waited = 0;
      while (exp_q.size() != 0) begin
         @(negedge axi_aclk);
         waited++;
         if (waited > 4 * WAIT_LIMIT) report_timeout("output drain");
      end
      check_value({test_name, " tvalid after drain"}, 128'(0), 128'(m_axis_tvalid));
   endtask

   // Holds the output, then checks that the input side stopped in time
   task automatic watch_stall(input int base);
      int waited;
      waited = 0;
      while (s_axis_tready) begin
         @(negedge axi_aclk);
         waited++;
         if (waited > WAIT_LIMIT) report_timeout("s_axis_tready to drop");
      end
      repeat (20) @(negedge axi_aclk);
      check_value({test_name, " tready held low"}, 128'(0), 128'(s_axis_tready));
      // Two free entries left when the input side stops
      check_value({test_name, " accepted beats"}, 128'(IN_DEPTH - 2),
                  128'(accepted_beats - base));
      set_ready_mode(1);
   endtask

   always @(negedge axi_aclk) begin
      case (ready_mode)
         0:       m_axis_tready = 1'b1;
         1:       m_axis_tready = 1'($random(bp_seed));
         default: m_axis_tready = 1'b0;
      endcase
   end

   ////////////////////////////////////////////////////////////
   // Output checker
   ////////////////////////////////////////////////////////////
   always @(posedge axi_aclk) begin
      exp_beat_t e;
      if (axi_resetn) begin
         // Output only once a whole packet is in
         if (m_axis_tvalid) begin
            check_value({test_name, " tvalid before tlast in"}, 128'(1),
                        128'(in_lasts > out_lasts));
         end
         if (m_axis_tvalid && m_axis_tready) begin
            if (exp_q.size() == 0) begin
               $display("Output beat seen with no beat expected in test %s", test_name);
               $display("Done: errors found");
               $fatal(1, "Unexpected output beat");
            end else begin
               e = exp_q.pop_front();
               check_value({test_name, " tdata"}, 128'(e.data), 128'(m_axis_tdata));
               check_value({test_name, " tstrb"}, 128'(e.strb), 128'(m_axis_tstrb));
               check_value({test_name, " tlast"}, 128'(e.last), 128'(m_axis_tlast));
               if (e.first) check_value({test_name, " tuser"}, e.user, m_axis_tuser);
               if (m_axis_tlast) out_lasts++;
            end
         end
         if (s_axis_tvalid && s_axis_tready) begin
            accepted_beats++;
            if (s_axis_tlast) in_lasts++;
         end
      end
   end

   initial begin
      byte_q_t bytes;
      int      base;
      axi_resetn    = 1'b0;
      s_axis_tdata  = '0;
      s_axis_tstrb  = '0;
      s_axis_tlast  = 1'b0;
      s_axis_tvalid = 1'b0;
      m_axis_tready = 1'b0;
      bp_seed       = $random(seed);
      repeat (16) @(negedge axi_aclk);
      axi_resetn = 1'b1;

      test_name = "after_reset";
      @(negedge axi_aclk);
      check_value({test_name, " tvalid"}, 128'(0), 128'(m_axis_tvalid));
      check_value({test_name, " tready"}, 128'(1), 128'(s_axis_tready));

      test_name = "short_packets";
      foreach (short_lens[i]) begin
         bytes.delete();
         for (int j = 0; j < short_lens[i]; j++) bytes.push_back(8'(j * 7 + short_lens[i]));
         send_packet(bytes);
      end
      idle_input();
      wait_drain();

      test_name = "random_back_to_back";
      repeat (20) send_random_packet(1, `AXIS_MAX_PKT_BYTES);
      idle_input();
      wait_drain();

      test_name = "random_backpressure";
      set_ready_mode(1);
      repeat (10) send_random_packet(1, `AXIS_MAX_PKT_BYTES);
      idle_input();
      wait_drain();

      test_name = "stalled_output";
      set_ready_mode(2);
      base = accepted_beats;
      fork
         begin
            repeat (3) send_random_packet(STALL_MIN_LEN, `AXIS_MAX_PKT_BYTES);
            idle_input();
         end
         watch_stall(base);
      join
      wait_drain();
      set_ready_mode(0);

      repeat (20) @(negedge axi_aclk);
      $display("Done: no errors");
      $finish;
   end

endmodule

`default_nettype wire
